/* hdl/ssr_indir_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Shared widths, vector types and port structs
// of the index indirection datapath
// ~~~~~~~~~~~~~~~~~~~~

package ssr_indir_pkg;

  // Memory word geometry
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned WordBytes    = DataWidth / 8;
  localparam int unsigned BytecntWidth = $clog2(WordBytes);

  // Address and pointer space
  localparam int unsigned AddrWidth    = 18;
  localparam int unsigned PointerWidth = 18;

  // Index and shift-and-add settings
  localparam int unsigned IndexWidth   = 16;
  localparam int unsigned ShiftWidth   = 3;
  localparam int unsigned IdxSizeWidth = 2;

  // Words in flight plus words buffered
  localparam int unsigned IndexCredits = 3;
  localparam int unsigned CreditWidth  = 2;

  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [PointerWidth-1:0] pointer_t;
  typedef logic [IndexWidth-1:0]   index_t;
  typedef logic [BytecntWidth-1:0] bytecnt_t;
  typedef logic [ShiftWidth-1:0]   shift_t;
  // Log2 of index bytes, 0 to 2 are legal
  typedef logic [IdxSizeWidth-1:0] idx_size_t;

  // Read request payload, always a whole aligned word
  typedef struct packed {
    pointer_t addr;
  } idx_req_t;

  // Read response payload
  typedef struct packed {
    data_t data;
  } idx_rsp_t;

  // Job settings, stable while a job runs
  typedef struct packed {
    pointer_t  base;
    shift_t    shift;
    idx_size_t size;
    bytecnt_t  offs_next;
  } indir_cfg_t;

  // Output payload towards the address consumer
  typedef struct packed {
    pointer_t pointer;
    logic     last;
  } mem_out_t;

endpackage

/* hdl/idx_fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Index word fetcher with credit counter
// and bound offset / extra word detection
// ~~~~~~~~~~~~~~~~~~~~

module idx_fetch (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      cfg_done_i,
  input  ssr_indir_pkg::pointer_t   natit_pointer_i,
  input  logic                      natit_done_i,
  input  ssr_indir_pkg::bytecnt_t   natit_boundoffs_i,
  output logic                      natit_ready_o,
  output logic                      natit_extraword_o,
  output ssr_indir_pkg::idx_req_t   idx_req_o,
  output logic                      idx_q_valid_o,
  input  logic                      idx_q_ready_i,
  input  logic                      word_pop_i,
  output logic                      last_word_o,
  output ssr_indir_pkg::bytecnt_t   last_byteoffs_o
);

  import ssr_indir_pkg::*;

  // Credits currently in use, either in flight or buffered
  logic [CreditWidth-1:0] cred_used_d, cred_used_q;
  logic                   cred_left;
  logic                   req_hs;

  // Byte offset of the first index within its word
  bytecnt_t first_byteoffs;

  // Request handshake with memory
  assign req_hs = idx_q_valid_o & idx_q_ready_i;

  // Free credit as long as not all words are taken
  assign cred_left = (cred_used_q != CreditWidth'(IndexCredits));

  // Fetch only while a job runs and the iterator still has words
  assign idx_q_valid_o = ~cfg_done_i & ~natit_done_i & cred_left;

  // Iterator steps on every accepted request
  assign natit_ready_o = req_hs;

  // Whole aligned word, low byte bits cleared
  assign idx_req_o.addr = {natit_pointer_i[AddrWidth-1:BytecntWidth], {BytecntWidth{1'b0}}};

  // Take on request, give back on pop; both at once leave the count as is
  always_comb begin
    cred_used_d = cred_used_q;
    case ({req_hs, word_pop_i})
      2'b10:   cred_used_d = cred_used_q + 1'b1;
      2'b01:   cred_used_d = cred_used_q - 1'b1;
      default: cred_used_d = cred_used_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cred_used_q <= '0;
    end else begin
      cred_used_q <= cred_used_d;
    end
  end

  // Iterator done and only one word outstanding: that word is the last one
  assign last_word_o = natit_done_i & (cred_used_q == CreditWidth'(1));

  // Offset of the last index, carry means the bound spills into one more word
  assign first_byteoffs = natit_pointer_i[BytecntWidth-1:0];
  assign {natit_extraword_o, last_byteoffs_o} = first_byteoffs + natit_boundoffs_i;

endmodule

/* hdl/idx_word_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Circular buffer of fetched index words
// ~~~~~~~~~~~~~~~~~~~~

module idx_word_fifo (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      push_i,
  input  ssr_indir_pkg::idx_rsp_t   wdata_i,
  input  logic                      pop_i,
  output logic                      empty_o,
  output ssr_indir_pkg::data_t      head_o
);

  import ssr_indir_pkg::*;

  // Word storage, sized by the credit count so it never overflows
  data_t mem_q [IndexCredits];

  logic [CreditWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CreditWidth-1:0] count_q;
  logic                   do_pop;

  // Pop is ignored on an empty buffer
  assign do_pop = pop_i & ~empty_o;

  // Pointer advance with wrap at the buffer depth
  function automatic logic [CreditWidth-1:0] ptr_next(input logic [CreditWidth-1:0] ptr);
    if (ptr == CreditWidth'(IndexCredits - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Payload write, no reset on storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= wdata_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Fill level follows push and pop
      case ({push_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Registered head, a word is visible the cycle after its strobe
  assign empty_o = (count_q == '0);
  assign head_o  = mem_q[rd_ptr_q];

endmodule

/* hdl/idx_serializer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Index serializer, last index detection
// and shift-and-add pointer output
// ~~~~~~~~~~~~~~~~~~~~

module idx_serializer (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       cfg_done_i,
  input  ssr_indir_pkg::indir_cfg_t  cfg_i,
  input  logic                       empty_i,
  input  ssr_indir_pkg::data_t       head_i,
  input  logic                       last_word_i,
  input  ssr_indir_pkg::bytecnt_t    last_byteoffs_i,
  output logic                       word_pop_o,
  output ssr_indir_pkg::mem_out_t    mem_o,
  output logic                       mem_valid_o,
  input  logic                       mem_ready_i
);

  import ssr_indir_pkg::*;

  // Byte counter within the head word
  bytecnt_t bytecnt_d, bytecnt_q;
  bytecnt_t bytecnt_incr;
  bytecnt_t bytecnt_next;
  logic     bytecnt_rovr;

  // Output transfer
  logic     mem_hs;

  // Serialized index
  data_t    ser_mask;
  data_t    ser_shifted;
  index_t   ser_idx;
  logic     at_last_offs;

  // Shift-and-add operands
  pointer_t idx_scaled;

  assign mem_hs = mem_valid_o & mem_ready_i;

  // Index size in bytes is 1, 2 or 4
  assign bytecnt_incr = bytecnt_t'(1) << cfg_i.size;
  assign bytecnt_next = bytecnt_q + bytecnt_incr;

  // Next index would start in a new word
  assign bytecnt_rovr = (bytecnt_next == '0);

  // Counter sits on the bound offset of the final word
  assign at_last_offs = (bytecnt_q == last_byteoffs_i);

  // Offs_next is loaded while idle, so a job starts at its initial offset
  always_comb begin
    bytecnt_d = bytecnt_q;
    if (cfg_done_i) begin
      bytecnt_d = cfg_i.offs_next;
    end else if (mem_hs) begin
      bytecnt_d = bytecnt_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bytecnt_q <= '0;
    end else begin
      bytecnt_q <= bytecnt_d;
    end
  end

  // Drop the head word after its final index went out
  assign word_pop_o = mem_hs & (last_word_i ? at_last_offs : bytecnt_rovr);

  // Bring the current byte to bit 0, then keep 8, 16 or 32 bits
  assign ser_mask    = ~({DataWidth{1'b1}} << (8 << cfg_i.size));
  assign ser_shifted = head_i >> {bytecnt_q, 3'b000};
  assign ser_idx     = index_t'(ser_shifted & ser_mask);

  // Index scaled to 8 byte elements, then by the job's extra shift
  assign idx_scaled = (pointer_t'(ser_idx) << BytecntWidth) << cfg_i.shift;

  // Valid as soon as a word is buffered
  assign mem_valid_o = ~empty_i;

  // Last flag does not depend on ready, so it holds under stall
  assign mem_o.pointer = cfg_i.base + idx_scaled;
  assign mem_o.last    = last_word_i & at_last_offs;

endmodule

/* hdl/ssr_indirector.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Indirection datapath top
// fetcher, word buffer and serializer
// ~~~~~~~~~~~~~~~~~~~~

module ssr_indirector (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // Job settings
  input  ssr_indir_pkg::indir_cfg_t  cfg_i,
  input  logic                       cfg_done_i,
  // Index memory port
  output ssr_indir_pkg::idx_req_t    idx_req_o,
  output logic                       idx_q_valid_o,
  input  logic                       idx_q_ready_i,
  input  logic                       idx_p_valid_i,
  input  ssr_indir_pkg::idx_rsp_t    idx_rsp_i,
  // Natural iterator upstream
  input  ssr_indir_pkg::pointer_t    natit_pointer_i,
  input  logic                       natit_done_i,
  input  ssr_indir_pkg::bytecnt_t    natit_boundoffs_i,
  output logic                       natit_ready_o,
  output logic                       natit_extraword_o,
  // Pointer output downstream
  output ssr_indir_pkg::mem_out_t    mem_o,
  output logic                       mem_valid_o,
  input  logic                       mem_ready_i
);

  import ssr_indir_pkg::*;

  // Serializer pops words, fetcher gets the credit back
  logic     word_pop;
  logic     last_word;
  bytecnt_t last_byteoffs;

  // Buffer head towards the serializer
  logic     fifo_empty;
  data_t    fifo_head;

  // Request side
  idx_fetch i_idx_fetch (
    .clk_i             ( clk_i             ),
    .reset_i           ( reset_i           ),
    .cfg_done_i        ( cfg_done_i        ),
    .natit_pointer_i   ( natit_pointer_i   ),
    .natit_done_i      ( natit_done_i      ),
    .natit_boundoffs_i ( natit_boundoffs_i ),
    .natit_ready_o     ( natit_ready_o     ),
    .natit_extraword_o ( natit_extraword_o ),
    .idx_req_o         ( idx_req_o         ),
    .idx_q_valid_o     ( idx_q_valid_o     ),
    .idx_q_ready_i     ( idx_q_ready_i     ),
    .word_pop_i        ( word_pop          ),
    .last_word_o       ( last_word         ),
    .last_byteoffs_o   ( last_byteoffs     )
  );

  // Response strobes write straight into the buffer
  idx_word_fifo i_idx_word_fifo (
    .clk_i   ( clk_i         ),
    .reset_i ( reset_i       ),
    .push_i  ( idx_p_valid_i ),
    .wdata_i ( idx_rsp_i     ),
    .pop_i   ( word_pop      ),
    .empty_o ( fifo_empty    ),
    .head_o  ( fifo_head     )
  );

  // Output side
  idx_serializer i_idx_serializer (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .cfg_done_i      ( cfg_done_i    ),
    .cfg_i           ( cfg_i         ),
    .empty_i         ( fifo_empty    ),
    .head_i          ( fifo_head     ),
    .last_word_i     ( last_word     ),
    .last_byteoffs_i ( last_byteoffs ),
    .word_pop_o      ( word_pop      ),
    .mem_o           ( mem_o         ),
    .mem_valid_o     ( mem_valid_o   ),
    .mem_ready_i     ( mem_ready_i   )
  );

endmodule

/* test/tb_model.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Index array reference model, expected pointer queue
// and compare tasks for the indirection testbench
// ~~~~~~~~~~~~~~~~~~~~

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

  // Expected pointers in array order with last flag and end-of-word mark
  pointer_t exp_ptr_q [$];
  logic     exp_last_q [$];
  logic     exp_end_q [$];

  task automatic report_error(input string msg);
    error_count++;
    $display("** Error at time %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  // Little endian index assembled byte by byte and cut to the index width
  function automatic index_t model_index(input int unsigned word, input int unsigned offs,
                                         input int unsigned nbytes);
    logic [31:0] v;
    v = '0;
    for (int b = int'(nbytes) - 1; b >= 0; b--) begin
      v = {v[23:0], mem_words[word][8 * (int'(offs) + b) +: 8]};
    end
    return v[15:0];
  endfunction

  // Element pointer is base plus index times 8 times 2**shift
  task automatic build_expect(input int unsigned start_word, input int unsigned offs,
                              input int unsigned last_offs, input int unsigned nbytes);
    int unsigned first;
    int unsigned final_b;
    pointer_t    scaled;
    for (int unsigned w = 0; w < job_words; w++) begin
      first   = (w == 0) ? offs : 0;
      final_b = (w == job_words - 1) ? last_offs : 8 - nbytes;
      for (int unsigned b = first; b <= final_b; b += nbytes) begin
        scaled = pointer_t'(model_index(start_word + w, b, nbytes)) << (3 + int'(cfg_i.shift));
        exp_ptr_q.push_back(cfg_i.base + scaled);
        exp_last_q.push_back((w == job_words - 1) && (b == final_b));
        exp_end_q.push_back(b == final_b);
      end
    end
  endtask

  task automatic check_pointer(input pointer_t got, input pointer_t exp, input string what);
    if (got !== exp) begin
      report_error($sformatf("%s: got 0x%05h, expected 0x%05h", what, got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("last flag is %b, expected %b", got, exp));
    end
  endtask

  task automatic check_extraword(input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("natit_extraword_o is %b, expected %b", got, exp));
    end
  endtask

  // Iterator handshake towards the natural iterator
  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("natit_ready_o is %b, expected %b", got, exp));
    end
  endtask

`endif

/* test/tb_ssr_indirector.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the indirection datapath
// memory and iterator drivers, LFSR, job sequencing
// ~~~~~~~~~~~~~~~~~~~~

module tb_ssr_indirector;

  import ssr_indir_pkg::*;

  localparam int unsigned MemWords   = 256;
  localparam int unsigned NumJobs    = 30;
  localparam int unsigned JobTimeout = 4000;

  logic       clk_i;
  logic       reset_i;
  indir_cfg_t cfg_i;
  logic       cfg_done_i;
  idx_req_t   idx_req_o;
  logic       idx_q_valid_o;
  logic       idx_q_ready_i;
  logic       idx_p_valid_i;
  idx_rsp_t   idx_rsp_i;
  pointer_t   natit_pointer_i;
  logic       natit_done_i;
  bytecnt_t   natit_boundoffs_i;
  logic       natit_ready_o;
  logic       natit_extraword_o;
  mem_out_t   mem_o;
  logic       mem_valid_o;
  logic       mem_ready_i;

  logic [15:0] lfsr_q;
  data_t       mem_words [MemWords];
  // Outstanding reads in order with the cycle their strobe is due
  pointer_t    rsp_addr_q [$];
  int unsigned rsp_due_q [$];
  int unsigned last_due, cyc, error_count;
  int unsigned accepted_total, consumed_total, job_accepted, job_words;
  pointer_t    job_start_ptr;
  // Expected extra word flag of the running job
  logic        job_extraword;
  logic        stalled_q;
  mem_out_t    held_q;

  `include "tb_model.svh"

  ssr_indirector ssr_indirector_i (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // Memory responses, ready stalls and the natural iterator on the falling edge
  task automatic drive_cycle(input logic running);
    int unsigned step;
    pointer_t    addr;
    idx_q_ready_i = (rand_bits(2) != 0);
    mem_ready_i   = (rand_bits(2) != 0);
    natit_done_i  = 1'b0;
    if (running) begin
      // Iterator stays on its final word once all words went out
      step            = (job_accepted < job_words) ? job_accepted : job_words - 1;
      natit_pointer_i = job_start_ptr + pointer_t'(8 * step);
      natit_done_i    = (job_accepted >= job_words);
    end
    if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
      addr           = rsp_addr_q.pop_front();
      void'(rsp_due_q.pop_front());
      idx_p_valid_i  = 1'b1;
      idx_rsp_i.data = mem_words[addr[10:3]];
    end else begin
      idx_p_valid_i = 1'b0;
      idx_rsp_i     = '0;
    end
  endtask

  task automatic run_job(input int unsigned job);
    int unsigned nbytes, start_word, low, offs, last_offs, timer;
    cfg_i.size  = idx_size_t'(job % 3);
    nbytes      = 1 << cfg_i.size;
    cfg_i.base  = pointer_t'(rand_bits(18));
    cfg_i.shift = shift_t'(rand_bits(3));
    job_words   = (rand_bits(3) % 6) + 1;
    start_word  = rand_bits(7);
    low         = rand_bits(3);
    offs        = rand_bits(3) & ~(nbytes - 1);
    last_offs   = rand_bits(3) & ~(nbytes - 1);
    if (job_words == 1 && last_offs < offs) begin
      last_offs = offs;
    end
    cfg_i.offs_next = bytecnt_t'(offs);
    // Pointer low offset plus bound offset lands on the last index
    natit_boundoffs_i = bytecnt_t'(last_offs - low);
    // Bound wraps into the next word when it lies below the pointer's own offset
    job_extraword     = (last_offs < low);
    job_start_ptr     = pointer_t'(start_word * 8 + low);
    job_accepted      = 0;
    build_expect(start_word, offs, last_offs, nbytes);
    // One idle edge so the byte counter picks up offs_next
    @(negedge clk_i);
    cfg_done_i = 1'b0;
    drive_cycle(1'b1);
    timer = 0;
    while (exp_ptr_q.size() != 0) begin
      @(negedge clk_i);
      drive_cycle(1'b1);
      timer++;
      if (timer > JobTimeout) begin
        report_failure($sformatf("Job %0d timed out with %0d pointers missing",
                                 job, exp_ptr_q.size()));
      end
    end
    cfg_done_i   = 1'b1;
    natit_done_i = 1'b0;
    repeat (3) begin
      @(negedge clk_i);
      drive_cycle(1'b0);
    end
  endtask

  // Sampled on the rising edge before any register of the DUT updates
  always @(posedge clk_i) begin
    int unsigned due;
    if (!reset_i) begin
      cyc++;
      if (cfg_done_i) begin
        if (mem_valid_o || idx_q_valid_o) begin
          report_error("valid output raised while no job runs");
        end
      end else begin
        check_extraword(natit_extraword_o, job_extraword);
      end
      if (stalled_q) begin
        if (!mem_valid_o) begin
          report_error("mem_valid_o dropped during a stall");
        end
        check_pointer(mem_o.pointer, held_q.pointer, "pointer changed during a stall");
        check_last(mem_o.last, held_q.last);
      end
      // Ready towards the iterator marks exactly the accepted request
      check_ready(natit_ready_o, idx_q_valid_o & idx_q_ready_i);
      if (idx_q_valid_o && idx_q_ready_i) begin
        // Requests walk whole words up from the first word of the array
        check_pointer(idx_req_o.addr, pointer_t'(8 * (job_start_ptr / 8 + job_accepted)),
                      "wrong request address");
        due = cyc + rand_bits(3) % 6;
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_addr_q.push_back(idx_req_o.addr);
        rsp_due_q.push_back(due);
        accepted_total++;
      end
      // Iterator advances on natit_ready_o
      if (natit_ready_o) begin
        job_accepted++;
      end
      if (mem_valid_o && mem_ready_i) begin
        if (exp_ptr_q.size() == 0) begin
          report_error("pointer emitted with no index left in the job");
        end else begin
          check_pointer(mem_o.pointer, exp_ptr_q[0], "wrong pointer");
          check_last(mem_o.last, exp_last_q[0]);
          if (exp_end_q[0]) begin
            consumed_total++;
          end
          void'(exp_ptr_q.pop_front());
          void'(exp_last_q.pop_front());
          void'(exp_end_q.pop_front());
        end
      end
      if (accepted_total - consumed_total > IndexCredits) begin
        report_error("more index words outstanding than credits");
      end
      stalled_q = mem_valid_o & ~mem_ready_i;
      held_q    = mem_o;
    end
  end

  initial begin
    lfsr_q = 16'd49664;
    {cyc, last_due, error_count, accepted_total, consumed_total} = '0;
    {job_accepted, job_words} = '0;
    job_extraword = 1'b0;
    stalled_q = 1'b0;
    held_q    = '0;
    reset_i   = 1'b1;
    cfg_i      = '0;
    cfg_done_i = 1'b1;
    {idx_q_ready_i, idx_p_valid_i, idx_rsp_i, mem_ready_i} = '0;
    {natit_pointer_i, natit_done_i, natit_boundoffs_i} = '0;
    job_start_ptr = '0;
    for (int unsigned w = 0; w < MemWords; w++) begin
      mem_words[w] = data_t'({rand_bits(32), rand_bits(32)});
    end
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    repeat (3) begin
      @(negedge clk_i);
      drive_cycle(1'b0);
    end
    for (int unsigned job = 0; job < NumJobs; job++) begin
      run_job(job);
    end
    if (error_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("=== FAIL ===");
      $fatal(1, "errors were found");
    end
  end

endmodule

/* flist.f */
+incdir+test
hdl/ssr_indir_pkg.sv
hdl/idx_fetch.sv
hdl/idx_word_fifo.sv
hdl/idx_serializer.sv
hdl/ssr_indirector.sv
test/tb_ssr_indirector.sv

/* Makefile */
TOOL   = verilator
FLAGS  = --binary --timing -j 0
TOP    = tb_ssr_indirector
FLIST  = flist.f
OBJDIR = obj_dir
BIN    = $(OBJDIR)/V$(TOP)

SRCS = $(wildcard hdl/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
